// ==== soc_settings.svh ====
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// region number sits in address bits 31..28
`define SOC_REGION_RAM    4'd0
`define SOC_REGION_TIMER  4'd1
`define SOC_REGION_GPIO   4'd2

`define SOC_RAM_WORDS     1024          // 4 KiB, word addressed by bits 11..2

`define SOC_GPIO_WIDTH    16            // pins per direction

// read value for any region without a slave
`define SOC_UNMAPPED_DATA 32'hdead_beef

`endif

// ==== soc_pkg.sv ====
package soc_pkg;

    typedef logic [31:0] addr_t;    // byte address
    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_t;      // one bit per byte lane
    typedef logic [3:0]  region_t;  // address[31:28]

    // data bus sequencer, only RAM reads leave idle
    typedef enum logic [1:0] {
        idle,
        ram_wait,
        done
    } bus_state_t;

endpackage

// ==== bus_if.sv ====
`timescale 1ns/100ps

interface bus_if import soc_pkg::*; ();

    addr_t address;
    word_t wdata;
    be_t   be;
    logic  read;        // level strobe, held while stall
    logic  write;
    word_t rdata;       // valid in the cycle stall is low
    logic  stall;

    modport master (
        output address, wdata, be, read, write,
        input  rdata, stall
    );

    modport slave (
        input  address, wdata, be, read, write,
        output rdata, stall
    );

endinterface

// ==== data_bus.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module data_bus import soc_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    bus_if.slave  cpu,
    bus_if.master ram_bus,
    bus_if.master timer_bus,
    bus_if.master gpio_bus,
    output logic  bus_error
);

    region_t    region;
    logic       sel_ram;
    logic       sel_timer;
    logic       sel_gpio;
    logic       request;
    logic       ram_read;
    logic       wait_stall;
    logic       slave_stall;
    bus_state_t state;
    bus_state_t state_next;

    assign region    = cpu.address[31:28];
    assign sel_ram   = (region == `SOC_REGION_RAM);
    assign sel_timer = (region == `SOC_REGION_TIMER);
    assign sel_gpio  = (region == `SOC_REGION_GPIO);
    assign request   = cpu.read | cpu.write;
    assign ram_read  = sel_ram & cpu.read;

    assign ram_bus.address   = cpu.address;
    assign ram_bus.wdata     = cpu.wdata;
    assign ram_bus.be        = cpu.be;
    assign ram_bus.read      = cpu.read & sel_ram;
    assign ram_bus.write     = cpu.write & sel_ram;

    assign timer_bus.address = cpu.address;
    assign timer_bus.wdata   = cpu.wdata;
    assign timer_bus.be      = cpu.be;
    assign timer_bus.read    = cpu.read & sel_timer;
    assign timer_bus.write   = cpu.write & sel_timer;

    assign gpio_bus.address  = cpu.address;
    assign gpio_bus.wdata    = cpu.wdata;
    assign gpio_bus.be       = cpu.be;
    assign gpio_bus.read     = cpu.read & sel_gpio;
    assign gpio_bus.write    = cpu.write & sel_gpio;

    // one wait state for the registered RAM read port
    always_comb begin
        state_next = state;
        wait_stall = 1'b0;
        case (state)
            idle, done: begin       // done may already see the next request
                if (ram_read) begin
                    wait_stall = 1'b1;
                    state_next = ram_wait;
                end else begin
                    state_next = idle;
                end
            end
            ram_wait: state_next = done;    // ram rdata valid, stall drops
            default:  state_next = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        slave_stall = 1'b0;
        cpu.rdata   = `SOC_UNMAPPED_DATA;
        if (sel_ram) begin
            slave_stall = ram_bus.stall;
            cpu.rdata   = ram_bus.rdata;
        end else if (sel_timer) begin
            slave_stall = timer_bus.stall;
            cpu.rdata   = timer_bus.rdata;
        end else if (sel_gpio) begin
            slave_stall = gpio_bus.stall;
            cpu.rdata   = gpio_bus.rdata;
        end
    end

    assign cpu.stall = request & (wait_stall | slave_stall);
    assign bus_error = request & ~(sel_ram | sel_timer | sel_gpio);   // write dropped

endmodule

// ==== ram_controller.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module ram_controller import soc_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    bus_if.slave bus
);

    localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

    word_t             mem [`SOC_RAM_WORDS];
    logic [IDX_W-1:0]  idx;
    word_t             rdata_q;

    assign idx = bus.address[IDX_W+1:2];    // word index

    always_ff @(posedge clk) begin
        if (bus.write) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.be[i]) begin
                    mem[idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
                end
            end
        end
    end

    // sampled in the stalled cycle, presented in the next
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (bus.read) begin
            rdata_q <= mem[idx];
        end
    end

    assign bus.rdata = rdata_q;
    assign bus.stall = 1'b0;        // wait state comes from data_bus

endmodule

// ==== timer_controller.sv ====
`timescale 1ns/100ps

module timer_controller import soc_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    bus_if.slave bus,
    output logic irq
);

    word_t count;
    word_t compare;
    logic  enable;
    logic  irq_status;
    logic  hit;
    logic  wr_count;
    logic  wr_compare;
    logic  wr_control;

    assign wr_count   = bus.write & (bus.address[3:2] == 2'd0);
    assign wr_compare = bus.write & (bus.address[3:2] == 2'd1);
    assign wr_control = bus.write & (bus.address[3:2] == 2'd2);
    assign hit        = enable & (count == compare);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count      <= '0;
            compare    <= '0;
            enable     <= 1'b0;
            irq_status <= 1'b0;
        end else begin
            if (wr_count) begin
                count <= bus.wdata;
            end else if (enable) begin
                count <= count + 1'b1;
            end
            if (wr_compare) begin
                compare <= bus.wdata;
            end
            if (wr_control) begin
                enable <= bus.wdata[0];
            end
            // sticky, write 1 to bit1 to clear
            irq_status <= (irq_status & ~(wr_control & bus.wdata[1])) | hit;
        end
    end

    always_comb begin
        case (bus.address[3:2])
            2'd0:    bus.rdata = count;
            2'd1:    bus.rdata = compare;
            2'd2:    bus.rdata = {30'b0, irq_status, enable};
            default: bus.rdata = '0;
        endcase
    end

    assign bus.stall = 1'b0;
    assign irq       = irq_status;

endmodule

// ==== gpio_controller.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module gpio_controller import soc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    bus_if.slave                       bus,
    output logic [`SOC_GPIO_WIDTH-1:0] pins_out,
    input  logic [`SOC_GPIO_WIDTH-1:0] pins_in
);

    logic [`SOC_GPIO_WIDTH-1:0] sync_1;
    logic [`SOC_GPIO_WIDTH-1:0] sync_2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pins_out <= '0;
            sync_1   <= '0;
            sync_2   <= '0;
        end else begin
            sync_1 <= pins_in;          // async pins
            sync_2 <= sync_1;
            if (bus.write && !bus.address[2]) begin
                for (int i = 0; i < `SOC_GPIO_WIDTH / 8; i++) begin
                    if (bus.be[i]) begin
                        pins_out[i*8 +: 8] <= bus.wdata[i*8 +: 8];
                    end
                end
            end
        end
    end

    // 0x0 output register, 0x4 synchronized inputs
    assign bus.rdata = bus.address[2] ? word_t'(sync_2) : word_t'(pins_out);
    assign bus.stall = 1'b0;

endmodule

// ==== soc_top.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module soc_top import soc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,

    input  addr_t                      address,
    input  word_t                      wdata,
    input  be_t                        be,
    input  logic                       read,
    input  logic                       write,
    output word_t                      rdata,
    output logic                       stall,
    output logic                       bus_error,

    output logic                       timer_irq,
    output logic [`SOC_GPIO_WIDTH-1:0] gpio_out,
    input  logic [`SOC_GPIO_WIDTH-1:0] gpio_in
);

    bus_if cpu_if();
    bus_if ram_if();
    bus_if timer_if();
    bus_if gpio_if();

    // board master onto the cpu segment
    assign cpu_if.address = address;
    assign cpu_if.wdata   = wdata;
    assign cpu_if.be      = be;
    assign cpu_if.read    = read;
    assign cpu_if.write   = write;
    assign rdata          = cpu_if.rdata;
    assign stall          = cpu_if.stall;

    data_bus data_bus_instance (
        .clk,
        .rst_n,
        .cpu       (cpu_if.slave),
        .ram_bus   (ram_if.master),
        .timer_bus (timer_if.master),
        .gpio_bus  (gpio_if.master),
        .bus_error
    );

    ram_controller ram_controller_instance (
        .clk,
        .rst_n,
        .bus (ram_if.slave)
    );

    timer_controller timer_controller_instance (
        .clk,
        .rst_n,
        .bus (timer_if.slave),
        .irq (timer_irq)
    );

    gpio_controller gpio_controller_instance (
        .clk,
        .rst_n,
        .bus      (gpio_if.slave),
        .pins_out (gpio_out),
        .pins_in  (gpio_in)
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

    always #(period_ns / 2) clk = ~clk;

endmodule

// ==== soc_props.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module soc_props import soc_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input addr_t address,
    input logic  read,
    input logic  write,
    input logic  stall,
    input logic  bus_error
);

    region_t region;
    int      failures = 0;  // failed property count

    assign region = address[31:28];

    // master holds the request across a wait state
    hold_during_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(address) && $stable(read) && $stable(write))
        else begin
            failures++;
            $error("request changed while stall was high");
        end

    stall_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> read)
        else begin
            failures++;
            $error("stall high without a read");
        end

    error_only_unmapped: assert property (@(posedge clk) disable iff (!rst_n)
        bus_error |-> (read || write) && region != `SOC_REGION_RAM
            && region != `SOC_REGION_TIMER && region != `SOC_REGION_GPIO)
        else begin
            failures++;
            $error("bus_error on a mapped region");
        end

endmodule

// ==== soc_tb.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module soc_tb import soc_pkg::*; ();

    localparam int cycle_budget = 20 + 60 + 60 + 20 + 20;  // reset, ram, timer, gpio, unmapped

    logic                       clk;
    logic                       rst_n;
    addr_t                      address;
    word_t                      wdata;
    be_t                        be;
    logic                       read;
    logic                       write;
    word_t                      rdata;
    logic                       stall;
    logic                       bus_error;
    logic                       timer_irq;
    logic [`SOC_GPIO_WIDTH-1:0] gpio_out;
    logic [`SOC_GPIO_WIDTH-1:0] gpio_in;
    word_t                      ram_model [`SOC_RAM_WORDS];
    int                         errors = 0;
    int                         tests_run = 0;
    int                         tests_failed = 0;
    int                         error_pulses = 0;

    tb_clk_gen clk_gen_instance (.clk, .rst_n);

    soc_top i_dut (.*);

    bind data_bus soc_props props_instance (
        .clk,
        .rst_n,
        .address (cpu.address),
        .read    (cpu.read),
        .write   (cpu.write),
        .stall   (cpu.stall),
        .bus_error
    );

    always @(negedge clk) begin
        if (bus_error) begin
            error_pulses++;
        end
    end

    task automatic compare_value(input string name, input word_t actual, input word_t expected);
        assert (actual === expected) else begin
            errors++;
            $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic confirm(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("at %0t ns: %s", $time, what);
        end
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - start);
        end
    endtask

    // one request, held until stall drops
    task automatic drive_access(input logic rd, input addr_t a, input word_t d, input be_t b,
                                output word_t q, output int stalls);
        stalls = 0;
        @(posedge clk);
        address <= a;
        wdata   <= d;
        be      <= b;
        read    <= rd;
        write   <= !rd;
        @(negedge clk);
        while (stall && stalls < 8) begin
            stalls++;
            @(negedge clk);
        end
        q = rdata;
        @(posedge clk);
        read  <= 1'b0;
        write <= 1'b0;
    endtask

    task automatic bus_write(input addr_t a, input word_t d, input be_t b);
        word_t q;
        int    stalls;
        drive_access(1'b0, a, d, b, q, stalls);
    endtask

    task automatic bus_read(input addr_t a, output word_t q, output int stalls);
        drive_access(1'b1, a, '0, 4'hf, q, stalls);
    endtask

    function automatic word_t merge_lanes(word_t old, word_t fresh, be_t b);
        word_t r;
        r = old;
        for (int i = 0; i < 4; i++) begin
            if (b[i]) begin
                r[i*8 +: 8] = fresh[i*8 +: 8];
            end
        end
        return r;
    endfunction

    task automatic reset_defaults();
        int    start;
        int    stalls;
        word_t q;
        start = errors;
        @(negedge clk);
        compare_value("stall", stall, 0);
        compare_value("bus_error", bus_error, 0);
        compare_value("timer_irq", timer_irq, 0);
        compare_value("gpio_out", gpio_out, 0);
        bus_read(32'h1000_0000, q, stalls);
        compare_value("timer count", q, 0);
        report_test("reset_defaults", start);
    endtask

    task automatic ram_random_access();
        int    start;
        int    stalls;
        addr_t a [6];
        word_t d;
        be_t   b;
        word_t q;
        start = errors;
        foreach (a[i]) begin
            a[i] = {20'h0, 10'($urandom), 2'b00};
            d = $urandom;
            bus_write(a[i], d, 4'hf);
            ram_model[a[i][11:2]] = d;
        end
        foreach (a[i]) begin
            d = $urandom;
            b = 4'($urandom);
            bus_write(a[i], d, b);
            ram_model[a[i][11:2]] = merge_lanes(ram_model[a[i][11:2]], d, b);
        end
        foreach (a[i]) begin
            bus_read(a[i], q, stalls);
            compare_value("rdata", q, ram_model[a[i][11:2]]);
            compare_value("ram read stall cycles", stalls, 1);
        end
        report_test("ram_random_access", start);
    endtask

    task automatic timer_compare_irq();
        int    start;
        int    stalls;
        int    n;
        int    waited;
        word_t q;
        start = errors;
        n = 16 + ($urandom % 16);
        bus_write(32'h1000_0000, 32'h0, 4'hf);
        bus_write(32'h1000_0004, word_t'(n), 4'hf);
        bus_write(32'h1000_0008, 32'h1, 4'hf);      // enable
        waited = 0;
        @(negedge clk);
        while (!timer_irq && waited < n + 8) begin
            waited++;
            @(negedge clk);
        end
        confirm(timer_irq, "timer_irq did not rise after the compare match");
        repeat (4) begin
            @(negedge clk);
            confirm(timer_irq, "timer_irq dropped before it was cleared");
        end
        bus_read(32'h1000_0000, q, stalls);
        confirm(q >= word_t'(n), "timer count read back below the compare value");
        bus_write(32'h1000_0008, 32'h2, 4'hf);      // clear status and stop
        @(negedge clk);
        compare_value("timer_irq", timer_irq, 0);
        report_test("timer_compare_irq", start);
    endtask

    task automatic gpio_lanes_and_sync();
        int                         start;
        int                         stalls;
        word_t                      q;
        logic [`SOC_GPIO_WIDTH-1:0] pins;
        start = errors;
        pins = `SOC_GPIO_WIDTH'($urandom);
        bus_write(32'h2000_0000, 32'h0000_a5c3, 4'hf);
        @(negedge clk);
        compare_value("gpio_out", gpio_out, 16'ha5c3);
        bus_write(32'h2000_0000, 32'h0000_1234, 4'b0010);  // upper byte only
        @(negedge clk);
        compare_value("gpio_out", gpio_out, 16'h12c3);
        @(posedge clk);
        gpio_in <= pins;
        repeat (1) @(posedge clk);
        bus_read(32'h2000_0004, q, stalls);
        compare_value("gpio input", q, word_t'(pins));
        report_test("gpio_lanes_and_sync", start);
    endtask

    task automatic unmapped_region();
        int                         start;
        int                         stalls;
        word_t                      q;
        logic [`SOC_GPIO_WIDTH-1:0] pins_before;
        start = errors;
        bus_write(32'h0000_0000, 32'h1357_9bdf, 4'hf);
        @(negedge clk);
        pins_before = gpio_out;
        error_pulses = 0;
        bus_read(32'h5000_0000, q, stalls);
        compare_value("rdata", q, 32'hdead_beef);
        compare_value("bus_error pulses", error_pulses, 1);
        bus_write(32'h5000_0000, 32'hffff_ffff, 4'hf);
        compare_value("bus_error pulses", error_pulses, 2);
        bus_read(32'h0000_0000, q, stalls);
        compare_value("ram word 0", q, 32'h1357_9bdf);
        compare_value("gpio_out", gpio_out, pins_before);
        report_test("unmapped_region", start);
    endtask

    initial begin
        void'($urandom(32'h948e));
        address = '0;
        wdata   = '0;
        be      = '0;
        read    = 1'b0;
        write   = 1'b0;
        gpio_in = '0;
        @(posedge rst_n);
        reset_defaults();
        ram_random_access();
        timer_compare_irq();
        gpio_lanes_and_sync();
        unmapped_region();
        errors += i_dut.data_bus_instance.props_instance.failures;  // bus protocol properties
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(cycle_budget * 2 * 20);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
soc_pkg.sv
bus_if.sv
data_bus.sv
ram_controller.sv
timer_controller.sv
gpio_controller.sv
soc_top.sv
tb_clk_gen.sv
soc_props.sv
soc_tb.sv

// ==== Bender.yml ====
package:
  name: soc_periph

sources:
  - include_dirs:
      - .
    files:
      - soc_pkg.sv
      - bus_if.sv
      - data_bus.sv
      - ram_controller.sv
      - timer_controller.sv
      - gpio_controller.sv
      - soc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - soc_props.sv
      - soc_tb.sv
